// ==== Makefile ====
# Verilator build and run of the cartridge loader testbench

VERILATOR ?= verilator
TOP       ?= snes_loader_tb
FILELIST  ?= snes_loader.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(wildcard source/*.sv) $(wildcard source/*.svh) $(wildcard verif/*.sv)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# The log decides the result, the binary status alone is not enough
run: $(BIN)
	$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^TB PASSED$$" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== snes_loader.f ====
+incdir+source
source/snes_loader_pkg.sv
source/cart_header_detect.sv
source/mem_clear_engine.sv
source/backup_sector_ctrl.sv
source/snes_loader_top.sv
verif/snes_loader_props.sv
verif/snes_loader_tb.sv

// ==== source/backup_sector_ctrl.sv ====
// Moves save RAM to and from the mounted save image sector by sector and holds the core meanwhile
`timescale 1ns/1ps
`default_nettype none
`include "snes_loader_params.svh"

module backup_sector_ctrl (
	input  wire                         clk_sys,
	input  wire                         RESET,
	input  wire snes_loader_pkg::dl_beat_t dl,
	input  wire [23:0]                  ram_mask,
	input  wire                         clear_busy,
	input  wire                         img_mounted,
	input  wire                         img_readonly,
	input  wire                         img_nonempty,
	input  wire                         load_req,
	input  wire                         save_req,
	input  wire                         autosave,
	input  wire                         osd_status,
	input  wire                         bsram_write,
	input  wire                         sd_ack,
	output snes_loader_pkg::sd_req_t    sd,
	output logic                        bk_pending,
	output logic                        core_hold
);

	logic        cart_dl;
	logic        cart_dl_q;
	logic        bk_ena;
	logic        load_act;
	logic        save_act;
	logic        load_q;
	logic        save_q;
	logic        ack_q;
	logic        bk_state;
	logic        bk_loading;
	logic        sd_rd;
	logic        sd_wr;
	logic [31:0] sd_lba;
	logic [31:0] last_lba;

	assign cart_dl  = dl.download && (dl.index == `SNES_CART_INDEX);
	assign last_lba = 32'(ram_mask[23:`SNES_SECTOR_SHIFT]);

	// Menu commands, or autosave once the menu opens with changes pending
	assign load_act = load_req & bk_ena;
	assign save_act = (save_req | (bk_pending & osd_status & autosave)) & bk_ena;

	// ========================================================================
	// Save enable and pending changes
	// ========================================================================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_dl_q  <= 1'b0;
			bk_ena     <= 1'b0;
			bk_pending <= 1'b0;
		end else begin
			cart_dl_q <= cart_dl;
			if (!cart_dl_q && cart_dl)
				bk_ena <= 1'b0;
			// The save image is mounted near the end of the download
			if (cart_dl && img_mounted && !img_readonly)
				bk_ena <= |ram_mask;
			if (bk_ena && !osd_status && bsram_write)
				bk_pending <= 1'b1;
			else if (bk_state || !bk_ena)
				bk_pending <= 1'b0;
		end
	end

	// ========================================================================
	// Sector sequencer
	// ========================================================================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			load_q     <= 1'b0;
			save_q     <= 1'b0;
			ack_q      <= 1'b0;
			bk_state   <= 1'b0;
			bk_loading <= 1'b0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
		end else begin
			load_q <= load_act;
			save_q <= save_act;
			ack_q  <= sd_ack;
			if (!ack_q && sd_ack) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end
			if (!bk_state) begin
				if ((!load_q && load_act) || (!save_q && save_act)) begin
					bk_state   <= 1'b1;
					bk_loading <= load_act;
					sd_lba     <= 32'd0;
					sd_rd      <= load_act;
					sd_wr      <= ~load_act;
				end
				// Pull the save image in right after the cartridge
				if (cart_dl_q && !cart_dl && img_nonempty && bk_ena) begin
					bk_state   <= 1'b1;
					bk_loading <= 1'b1;
					sd_lba     <= 32'd0;
					sd_rd      <= 1'b1;
					sd_wr      <= 1'b0;
				end
			end else if (ack_q && !sd_ack) begin
				if (sd_lba >= last_lba) begin
					bk_state   <= 1'b0;
					bk_loading <= 1'b0;
				end else begin
					sd_lba <= sd_lba + 32'd1;
					sd_rd  <= bk_loading;
					sd_wr  <= ~bk_loading;
				end
			end
		end
	end

	assign sd.lba = sd_lba;
	assign sd.rd  = sd_rd;
	assign sd.wr  = sd_wr;

	assign core_hold = RESET | cart_dl | clear_busy | bk_loading;

endmodule

`default_nettype wire

// ==== source/cart_header_detect.sv ====
// Recovers ROM type, memory masks and video region from a streamed cartridge image
`timescale 1ns/1ps
`default_nettype none
`include "snes_loader_params.svh"

module cart_header_detect (
	input  wire                         clk_sys,
	input  wire                         RESET,
	input  wire snes_loader_pkg::dl_beat_t dl,
	input  wire [2:0]                   header_mode,
	input  wire [1:0]                   region_sel,
	output snes_loader_pkg::cart_info_t cart_info,
	output logic                        pal
);

	logic        cart_dl;
	logic [3:0]  rom_code;
	logic [3:0]  ram_code;
	logic [3:0]  rom_code_d;
	logic [3:0]  ram_code_d;
	logic [7:0]  rom_type_d;
	logic        region_d;
	logic        use_size_words;
	logic [24:0] size_addr;

	assign cart_dl = dl.download && (dl.index == `SNES_CART_INDEX);

	// Location of the internal header for the forced mappings
	always_comb begin
		case (header_mode)
			3'd2:    size_addr = `SNES_LOROM_SIZE_ADDR;
			3'd3:    size_addr = `SNES_HIROM_SIZE_ADDR;
			default: size_addr = `SNES_EXHIROM_SIZE_ADDR;
		endcase
	end

	assign use_size_words = (header_mode >= 3'd2) && (header_mode <= 3'd4);

	// Next header fields for the current beat
	always_comb begin
		rom_code_d = rom_code;
		ram_code_d = ram_code;
		rom_type_d = cart_info.rom_type;
		region_d   = cart_info.region;
		if (dl.addr == 25'd0) begin
			rom_code_d = `SNES_DEFAULT_ROM_SIZE;
			ram_code_d = 4'd0;
			// Auto mode trusts the copier header byte if it is set
			if (header_mode == 3'd0 && dl.data[7:0] != 8'd0)
				{ram_code_d, rom_code_d} = dl.data[7:0];
			case (header_mode)
				3'd1, 3'd2: rom_type_d = 8'd0;
				3'd3:       rom_type_d = 8'd1;
				3'd4:       rom_type_d = 8'd2;
				default:    rom_type_d = dl.data[15:8];
			endcase
		end
		if (dl.addr == 25'd2)
			region_d = dl.data[8];
		if (use_size_words) begin
			if (dl.addr == size_addr)
				rom_code_d = dl.data[11:8];
			if (dl.addr == size_addr + 25'd2)
				ram_code_d = dl.data[3:0];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_code            <= `SNES_DEFAULT_ROM_SIZE;
			ram_code            <= 4'd0;
			cart_info.rom_type  <= 8'd0;
			cart_info.rom_mask  <= (24'd1024 << `SNES_DEFAULT_ROM_SIZE) - 24'd1;
			cart_info.ram_mask  <= 24'd0;
			cart_info.region    <= 1'b0;
			pal                 <= 1'b0;
		end else if (cart_dl) begin
			if (dl.wr) begin
				rom_code           <= rom_code_d;
				ram_code           <= ram_code_d;
				cart_info.rom_type <= rom_type_d;
				cart_info.rom_mask <= (24'd1024 << rom_code_d) - 24'd1;
				cart_info.ram_mask <= (ram_code_d != 4'd0) ?
					(24'd1024 << ram_code_d) - 24'd1 : 24'd0;
				cart_info.region   <= region_d;
			end
		end else begin
			// Region held still while the image streams in
			pal <= (region_sel == 2'd0) ? cart_info.region : region_sel[1];
		end
	end

endmodule

`default_nettype wire

// ==== source/mem_clear_engine.sv ====
// Sweeps the work memories with a power-on fill pattern at the start of each cartridge load
`timescale 1ns/1ps
`default_nettype none
`include "snes_loader_params.svh"

module mem_clear_engine #(
	parameter int FILL_ADDR_BITS = `SNES_FILL_ADDR_BITS
) (
	input  wire                         clk_sys,
	input  wire                         RESET,
	input  wire snes_loader_pkg::dl_beat_t dl,
	input  wire [1:0]                   wram_pattern,
	input  wire [1:0]                   aram_pattern,
	output snes_loader_pkg::fill_req_t  fill,
	output logic                        clear_busy
);

	logic                            cart_dl;
	logic                            cart_dl_q;
	logic                            wait_q;
	logic [FILL_ADDR_BITS-1:0]       addr_q;
	logic [`SNES_FILL_ADDR_BITS-1:0] ext_addr;

	// Fill byte for a pattern code at one address
	function automatic logic [7:0] pattern_byte(input logic [1:0] code,
		input logic [`SNES_FILL_ADDR_BITS-1:0] a);
		case (code)
			2'd0:    pattern_byte = (a[8] ^ a[2]) ? 8'h66 : 8'h99;
			2'd1:    pattern_byte = (a[9] ^ a[0]) ? 8'hFF : 8'h00;
			2'd2:    pattern_byte = 8'h55;
			default: pattern_byte = 8'hFF;
		endcase
	endfunction

	assign cart_dl = dl.download && (dl.index == `SNES_CART_INDEX);

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_dl_q  <= 1'b0;
			clear_busy <= 1'b0;
			wait_q     <= 1'b0;
			addr_q     <= '0;
		end else begin
			cart_dl_q <= cart_dl;
			if (!cart_dl_q && cart_dl)
				clear_busy <= 1'b1;
			if (clear_busy) begin
				// Write on one cycle, step on the next
				wait_q <= ~wait_q;
				if (wait_q)
					addr_q <= addr_q + 1'b1;
				if (wait_q && (&addr_q))
					clear_busy <= 1'b0;
			end else begin
				wait_q <= 1'b0;
				addr_q <= '0;
			end
		end
	end

	always_comb begin
		ext_addr                       = '0;
		ext_addr[FILL_ADDR_BITS-1:0]   = addr_q;
		fill.addr                      = ext_addr;
		fill.we                        = clear_busy & ~wait_q;
		fill.wram_data                 = pattern_byte(wram_pattern, ext_addr);
		fill.aram_data                 = pattern_byte(aram_pattern, ext_addr);
	end

endmodule

`default_nettype wire

// ==== source/snes_loader_params.svh ====
// Shared loader constants for header offsets, size-field addresses and sweep widths
`ifndef SNES_LOADER_PARAMS_SVH
`define SNES_LOADER_PARAMS_SVH

// ============================================================================
// Image layout
// ============================================================================

// Copier header that precedes the ROM data in the download stream
`define SNES_HDR_OFFSET 25'd512

// Size word of each mapping; the save-size word follows two bytes higher
`define SNES_LOROM_SIZE_ADDR (25'h7FD6 + `SNES_HDR_OFFSET)
`define SNES_HIROM_SIZE_ADDR (25'hFFD6 + `SNES_HDR_OFFSET)
`define SNES_EXHIROM_SIZE_ADDR (25'h40FFD6 + `SNES_HDR_OFFSET)

// Size code used when the header gives none
`define SNES_DEFAULT_ROM_SIZE 4'hC

// ============================================================================
// Memories and transfers
// ============================================================================

// Address width of the power-on clear sweep
`define SNES_FILL_ADDR_BITS 18

// Bytes per save-image sector as a power of two
`define SNES_SECTOR_SHIFT 9

// Host download index of a cartridge image
`define SNES_CART_INDEX 8'd0

`endif

// ==== source/snes_loader_pkg.sv ====
// Packed struct types passed between the loader units and used by the testbench
`default_nettype none
`include "snes_loader_params.svh"

package snes_loader_pkg;

	// ========================================================================
	// Host download stream
	// ========================================================================

	// One word beat from the host, addr is a byte address
	typedef struct packed {
		logic        download;
		logic [7:0]  index;
		logic [24:0] addr;
		logic [15:0] data;
		logic        wr;
	} dl_beat_t;

	// Cartridge description handed to the console core
	typedef struct packed {
		logic [7:0]  rom_type;
		logic [23:0] rom_mask;
		logic [23:0] ram_mask;
		logic        region;
	} cart_info_t;

	// ========================================================================
	// Memory side
	// ========================================================================

	// One write of the clear sweep, same address for WRAM and ARAM
	typedef struct packed {
		logic [`SNES_FILL_ADDR_BITS-1:0] addr;
		logic                            we;
		logic [7:0]                      wram_data;
		logic [7:0]                      aram_data;
	} fill_req_t;

	// Sector request to the save card, levels held until acknowledged
	typedef struct packed {
		logic [31:0] lba;
		logic        rd;
		logic        wr;
	} sd_req_t;

endpackage

`default_nettype wire

// ==== source/snes_loader_top.sv ====
// Cartridge loading support block; header detection, memory clear and save-RAM backup
`timescale 1ns/1ps
`default_nettype none
`include "snes_loader_params.svh"

module snes_loader_top #(
	parameter int FILL_ADDR_BITS = `SNES_FILL_ADDR_BITS
) (
	input  wire                         clk_sys,
	input  wire                         RESET,
	input  wire snes_loader_pkg::dl_beat_t dl,
	input  wire [2:0]                   header_mode,
	input  wire [1:0]                   region_sel,
	input  wire [1:0]                   wram_pattern,
	input  wire [1:0]                   aram_pattern,
	input  wire                         img_mounted,
	input  wire                         img_readonly,
	input  wire                         img_nonempty,
	input  wire                         load_req,
	input  wire                         save_req,
	input  wire                         autosave,
	input  wire                         osd_status,
	input  wire                         bsram_write,
	input  wire                         sd_ack,
	output snes_loader_pkg::cart_info_t cart_info,
	output logic                        pal,
	output snes_loader_pkg::fill_req_t  fill,
	output logic                        clear_busy,
	output snes_loader_pkg::sd_req_t    sd,
	output logic                        bk_pending,
	output logic                        core_hold
);

	// ========================================================================
	// Download stream consumers
	// ========================================================================

	cart_header_detect u_hdr (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.dl          (dl),
		.header_mode (header_mode),
		.region_sel  (region_sel),
		.cart_info   (cart_info),
		.pal         (pal)
	);

	mem_clear_engine #(
		.FILL_ADDR_BITS (FILL_ADDR_BITS)
	) u_clear (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.dl           (dl),
		.wram_pattern (wram_pattern),
		.aram_pattern (aram_pattern),
		.fill         (fill),
		.clear_busy   (clear_busy)
	);

	// Save RAM size from the header, hold while the clear runs
	backup_sector_ctrl u_bk (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.dl           (dl),
		.ram_mask     (cart_info.ram_mask),
		.clear_busy   (clear_busy),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_nonempty (img_nonempty),
		.load_req     (load_req),
		.save_req     (save_req),
		.autosave     (autosave),
		.osd_status   (osd_status),
		.bsram_write  (bsram_write),
		.sd_ack       (sd_ack),
		.sd           (sd),
		.bk_pending   (bk_pending),
		.core_hold    (core_hold)
	);

endmodule

`default_nettype wire

// ==== verif/snes_loader_props.sv ====
// Concurrent checks on the loader top-level ports, attached to the top level by bind
`timescale 1ns/1ps
`default_nettype none

module snes_loader_props (
	input wire                            clk_sys,
	input wire                            RESET,
	input wire snes_loader_pkg::fill_req_t fill,
	input wire snes_loader_pkg::sd_req_t   sd,
	input wire                            clear_busy,
	input wire                            core_hold
);

	// Save card sees one direction at a time
	a_one_direction: assert property (@(posedge clk_sys) disable iff (RESET)
		!(sd.rd && sd.wr))
		else $error("save card read and write levels high together");

	// Clear sweep writes every second cycle at most
	a_fill_spacing: assert property (@(posedge clk_sys) disable iff (RESET)
		fill.we |=> !fill.we)
		else $error("fill strobe high on two consecutive clocks");

	// Core stays in reset for the whole sweep
	a_hold_on_clear: assert property (@(posedge clk_sys) disable iff (RESET)
		clear_busy |-> core_hold)
		else $error("core_hold low while the clear sweep runs");

endmodule

bind snes_loader_top snes_loader_props props_i (
	.clk_sys    (clk_sys),
	.RESET      (RESET),
	.fill       (fill),
	.sd         (sd),
	.clear_busy (clear_busy),
	.core_hold  (core_hold)
);

`default_nettype wire

// ==== verif/snes_loader_tb.sv ====
// Table-driven testbench for the cartridge loader, run as the simulation top through the file list
`timescale 1ns/1ps
`default_nettype none
`include "snes_loader_params.svh"

module snes_loader_tb;

	import snes_loader_pkg::*;

	localparam int FILL_BITS      = 10;
	localparam int SWEEP_WRITES   = 1 << FILL_BITS;
	localparam int NUM_TESTS      = 6;
	localparam int MAX_SECTORS    = 16;
	localparam int SECTOR_CYCLES  = 8;
	localparam int TIMEOUT_CYCLES =
		2 * NUM_TESTS * (2 * SWEEP_WRITES + 2 * MAX_SECTORS * SECTOR_CYCLES + 64);

	typedef struct packed {
		logic [2:0]  header_mode;
		logic [15:0] word0;
		logic [15:0] word2;
		logic [15:0] rom_word;
		logic [15:0] ram_word;
		logic [1:0]  region_sel;
		logic [1:0]  wram_pattern;
		logic [1:0]  aram_pattern;
		logic        mounted;
		logic [7:0]  exp_type;
		logic [23:0] exp_rom_mask;
		logic [23:0] exp_ram_mask;
		logic        exp_pal;
	} test_entry_t;

	// mode  word0  word2  rom word  ram word  region  wram  aram  mounted  type  rom  ram  pal
	localparam test_entry_t TESTS [NUM_TESTS] = '{
		'{3'd0, 16'h2A38, 16'h0100, 16'h0900, 16'h0005, 2'd0, 2'd0, 2'd1, 1'b1,
			8'h2A, 24'h03FFFF, 24'h001FFF, 1'b1},
		'{3'd0, 16'h0500, 16'h0000, 16'h0900, 16'h0005, 2'd0, 2'd2, 2'd3, 1'b1,
			8'h05, 24'h3FFFFF, 24'h000000, 1'b0},
		'{3'd1, 16'h1234, 16'h0100, 16'h0900, 16'h0005, 2'd1, 2'd3, 2'd0, 1'b0,
			8'h00, 24'h3FFFFF, 24'h000000, 1'b0},
		'{3'd2, 16'h7700, 16'h0000, 16'h0A00, 16'h0001, 2'd3, 2'd1, 2'd2, 1'b1,
			8'h00, 24'h0FFFFF, 24'h0007FF, 1'b1},
		'{3'd3, 16'h0033, 16'h0100, 16'h0B00, 16'h0002, 2'd0, 2'd0, 2'd0, 1'b1,
			8'h01, 24'h1FFFFF, 24'h000FFF, 1'b1},
		'{3'd4, 16'h0000, 16'h0000, 16'h0C00, 16'h0000, 2'd0, 2'd1, 2'd1, 1'b1,
			8'h02, 24'h3FFFFF, 24'h000000, 1'b0}
	};

	logic        clk_sys;
	logic        RESET;
	dl_beat_t    dl;
	logic [2:0]  header_mode;
	logic [1:0]  region_sel;
	logic [1:0]  wram_pattern;
	logic [1:0]  aram_pattern;
	logic        img_mounted;
	logic        img_readonly;
	logic        img_nonempty;
	logic        load_req;
	logic        save_req;
	logic        autosave;
	logic        osd_status;
	logic        bsram_write;
	logic        sd_ack;
	cart_info_t  cart_info;
	logic        pal;
	fill_req_t   fill;
	logic        clear_busy;
	sd_req_t     sd;
	logic        bk_pending;
	logic        core_hold;

	int          errors = 0;
	int          checks = 0;
	int          cycle_count = 0;
	int unsigned seed_init;

	snes_loader_top #(
		.FILL_ADDR_BITS (FILL_BITS)
	) dut_i (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.dl           (dl),
		.header_mode  (header_mode),
		.region_sel   (region_sel),
		.wram_pattern (wram_pattern),
		.aram_pattern (aram_pattern),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_nonempty (img_nonempty),
		.load_req     (load_req),
		.save_req     (save_req),
		.autosave     (autosave),
		.osd_status   (osd_status),
		.bsram_write  (bsram_write),
		.sd_ack       (sd_ack),
		.cart_info    (cart_info),
		.pal          (pal),
		.fill         (fill),
		.clear_busy   (clear_busy),
		.sd           (sd),
		.bk_pending   (bk_pending),
		.core_hold    (core_hold)
	);

	always #10 clk_sys = ~clk_sys;

	// Watchdog sized from the table length
	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the DUT stopped making progress", cycle_count);
			$display("TB FAILED");
			$finish;
		end
	end

	// ========================================================================
	// Compare tasks
	// ========================================================================

	task automatic check_cart_info(input cart_info_t got, input cart_info_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH t=%0t cart_info got %h/%h/%h/%b expected %h/%h/%h/%b",
				$time, got.rom_type, got.rom_mask, got.ram_mask, got.region,
				exp.rom_type, exp.rom_mask, exp.ram_mask, exp.region);
		end
	endtask

	task automatic check_fill(input fill_req_t got, input fill_req_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH t=%0t fill got %h/%b/%h/%h expected %h/%b/%h/%h",
				$time, got.addr, got.we, got.wram_data, got.aram_data,
				exp.addr, exp.we, exp.wram_data, exp.aram_data);
		end
	endtask

	task automatic check_sd(input sd_req_t got, input sd_req_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH t=%0t sd got lba %0d rd %b wr %b, expected lba %0d rd %b wr %b",
				$time, got.lba, got.rd, got.wr, exp.lba, exp.rd, exp.wr);
		end
	endtask

	task automatic check_level(input logic got, input logic exp, input string name);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH t=%0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_count(input int got, input int exp, input string name);
		checks++;
		if (got != exp) begin
			errors++;
			$display("MISMATCH t=%0t %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	// ========================================================================
	// Reference rules and host model
	// ========================================================================

	// Power-on fill byte for a pattern code at one sweep address
	function automatic logic [7:0] expected_fill_byte(input logic [1:0] code,
		input int unsigned a);
		case (code)
			2'd0:    expected_fill_byte = (((a >> 8) & 1) != ((a >> 2) & 1)) ? 8'h66 : 8'h99;
			2'd1:    expected_fill_byte = (((a >> 9) & 1) != (a & 1)) ? 8'hFF : 8'h00;
			2'd2:    expected_fill_byte = 8'h55;
			default: expected_fill_byte = 8'hFF;
		endcase
	endfunction

	function automatic logic [24:0] size_addr_for(input logic [2:0] mode);
		if (mode == 3'd3)
			size_addr_for = `SNES_HIROM_SIZE_ADDR;
		else if (mode == 3'd4)
			size_addr_for = `SNES_EXHIROM_SIZE_ADDR;
		else
			size_addr_for = `SNES_LOROM_SIZE_ADDR;
	endfunction

	task automatic write_beat(input logic [24:0] addr, input logic [15:0] data);
		dl.addr = addr;
		dl.data = data;
		dl.wr   = 1'b1;
		@(negedge clk_sys);
		dl.wr   = 1'b0;
		@(negedge clk_sys);
	endtask

	// Streams just the header beats inside one download level
	task automatic download_image(input test_entry_t t);
		logic        pal_before;
		logic [24:0] size_addr;
		cart_info_t  exp_info;
		size_addr          = size_addr_for(t.header_mode);
		exp_info.rom_type  = t.exp_type;
		exp_info.rom_mask  = t.exp_rom_mask;
		exp_info.ram_mask  = t.exp_ram_mask;
		exp_info.region    = t.word2[8];
		header_mode        = t.header_mode;
		region_sel         = t.region_sel;
		wram_pattern       = t.wram_pattern;
		aram_pattern       = t.aram_pattern;
		img_mounted        = t.mounted;
		img_nonempty       = t.mounted;
		dl.index           = `SNES_CART_INDEX;
		dl.download        = 1'b1;
		pal_before         = pal;
		@(negedge clk_sys);
		write_beat(25'd0, t.word0);
		write_beat(25'd2, t.word2);
		write_beat(size_addr, t.rom_word);
		write_beat(size_addr + 25'd2, t.ram_word);
		@(negedge clk_sys);
		check_level(pal, pal_before, "pal during download");
		dl.download = 1'b0;
		@(negedge clk_sys);
		check_cart_info(cart_info, exp_info);
	endtask

	task automatic watch_sweep(input logic [1:0] wcode, input logic [1:0] acode);
		fill_req_t exp;
		int        strobes;
		strobes = 0;
		while (!clear_busy)
			@(negedge clk_sys);
		while (clear_busy) begin
			if (fill.we) begin
				exp.addr      = strobes[`SNES_FILL_ADDR_BITS-1:0];
				exp.we        = 1'b1;
				exp.wram_data = expected_fill_byte(wcode, strobes);
				exp.aram_data = expected_fill_byte(acode, strobes);
				check_fill(fill, exp);
				strobes++;
			end
			@(negedge clk_sys);
		end
		check_count(strobes, SWEEP_WRITES, "fill strobes");
	endtask

	// Save card with random acknowledge delay and length
	task automatic serve_card(input logic reading, input int last_sector, input logic hold_exp);
		sd_req_t exp;
		sd_req_t dropped;
		int      delay;
		int      ack_len;
		for (int s = 0; s <= last_sector; s++) begin
			while (!(sd.rd || sd.wr))
				@(negedge clk_sys);
			exp.lba    = 32'(s);
			exp.rd     = reading;
			exp.wr     = ~reading;
			dropped    = exp;
			dropped.rd = 1'b0;
			dropped.wr = 1'b0;
			check_sd(sd, exp);
			check_level(core_hold, hold_exp, "core_hold");
			// A load still running keeps the core held after the sweep
			if (reading && s == last_sector) begin
				while (clear_busy)
					@(negedge clk_sys);
				check_sd(sd, exp);
				check_level(core_hold, 1'b1, "core_hold after sweep");
			end
			delay   = int'($urandom % 4);
			ack_len = 1 + int'($urandom % 2);
			repeat (delay) begin
				@(negedge clk_sys);
				check_sd(sd, exp);
			end
			sd_ack = 1'b1;
			@(negedge clk_sys);
			check_sd(sd, dropped);
			repeat (ack_len - 1)
				@(negedge clk_sys);
			sd_ack = 1'b0;
			@(negedge clk_sys);
		end
	endtask

	task automatic run_autosave(input int last_sector);
		bsram_write = 1'b1;
		@(negedge clk_sys);
		bsram_write = 1'b0;
		check_level(bk_pending, 1'b1, "bk_pending after save-RAM write");
		osd_status = 1'b1;
		@(negedge clk_sys);
		serve_card(1'b0, last_sector, 1'b0);
		check_level(bk_pending, 1'b0, "bk_pending after save");
		osd_status = 1'b0;
		@(negedge clk_sys);
	endtask

	// ========================================================================
	// Test sequence
	// ========================================================================

	initial begin
		test_entry_t t;
		logic        expect_xfer;
		int          last_sector;
		int          errors_before;
		seed_init    = $urandom(32'hdca3);
		clk_sys      = 1'b0;
		RESET        = 1'b1;
		dl           = '0;
		header_mode  = 3'd0;
		region_sel   = 2'd0;
		wram_pattern = 2'd0;
		aram_pattern = 2'd0;
		img_mounted  = 1'b0;
		img_readonly = 1'b0;
		img_nonempty = 1'b0;
		load_req     = 1'b0;
		save_req     = 1'b0;
		autosave     = 1'b1;
		osd_status   = 1'b0;
		bsram_write  = 1'b0;
		sd_ack       = 1'b0;
		repeat (3)
			@(negedge clk_sys);
		RESET = 1'b0;
		@(negedge clk_sys);
		check_level(sd.rd, 1'b0, "sd.rd after reset");
		check_level(sd.wr, 1'b0, "sd.wr after reset");
		check_level(bk_pending, 1'b0, "bk_pending after reset");
		check_level(clear_busy, 1'b0, "clear_busy after reset");
		check_level(fill.we, 1'b0, "fill.we after reset");

		for (int i = 0; i < NUM_TESTS; i++) begin
			t             = TESTS[i];
			errors_before = errors;
			expect_xfer   = t.mounted && (t.exp_ram_mask != 24'd0);
			last_sector   = int'(t.exp_ram_mask[23:`SNES_SECTOR_SHIFT]);
			fork
				download_image(t);
				watch_sweep(t.wram_pattern, t.aram_pattern);
				if (expect_xfer)
					serve_card(1'b1, last_sector, 1'b1);
			join
			// Hold released once the sweep and any load are done
			check_level(core_hold, 1'b0, "core_hold after clear");
			check_level(sd.rd, 1'b0, "sd.rd idle");
			check_level(sd.wr, 1'b0, "sd.wr idle");
			check_level(pal, t.exp_pal, "pal");
			if (expect_xfer)
				run_autosave(last_sector);
			$display("Test %0d header mode %0d: %0d errors", i, t.header_mode,
				errors - errors_before);
		end

		$display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire
